// File: hdl/aluShifter.sv
// Operand barrel shifter with carry-out, followed by the ALU and its NZCV flags
module aluShifter import legPkg::*; (
  input  logic [31:0] srcA,
  input  logic [31:0] srcB,
  input  shiftT       shiftType,
  input  logic [4:0]  shiftAmt,
  input  logic        shiftEn,
  input  aluOpT       aluOp,
  input  logic        carryIn,
  output logic [31:0] result,
  output flagsT       flags
);

  logic [31:0] shOut;
  logic        shCarry;
  logic [63:0] rorDbl;
  logic [4:0]  lslIdx, rIdx;
  logic [31:0] addX, addY;
  logic        addCin;
  logic [32:0] sum;

  // Index of the last bit shifted out
  assign lslIdx = 5'd0 - shiftAmt;
  assign rIdx   = shiftAmt - 5'd1;
  assign rorDbl = {srcB, srcB} >> shiftAmt;

  // ==============================
  // Shifter
  // ==============================

  // Amount zero keeps the ARM meanings LSR #32, ASR #32 and RRX
  always_comb begin
    shOut   = srcB;
    shCarry = carryIn;
    if (shiftEn) begin
      case (shiftType)
        shLsl: begin
          if (shiftAmt != 5'd0) begin
            shOut   = srcB << shiftAmt;
            shCarry = srcB[lslIdx];
          end
        end
        shLsr: begin
          shOut   = (shiftAmt == 5'd0) ? 32'd0 : (srcB >> shiftAmt);
          shCarry = (shiftAmt == 5'd0) ? srcB[31] : srcB[rIdx];
        end
        shAsr: begin
          shOut   = (shiftAmt == 5'd0) ? {32{srcB[31]}} : 32'($signed(srcB) >>> shiftAmt);
          shCarry = (shiftAmt == 5'd0) ? srcB[31] : srcB[rIdx];
        end
        default: begin
          shOut   = (shiftAmt == 5'd0) ? {carryIn, srcB[31:1]} : rorDbl[31:0];
          shCarry = (shiftAmt == 5'd0) ? srcB[0] : srcB[rIdx];
        end
      endcase
    end
  end

  // ==============================
  // ALU
  // ==============================

  // Subtracts invert one input and add one
  always_comb begin
    addX   = srcA;
    addY   = shOut;
    addCin = 1'b0;
    case (aluOp)
      opSub, opCmp: begin
        addY   = ~shOut;
        addCin = 1'b1;
      end
      opRsb: begin
        addX   = shOut;
        addY   = ~srcA;
        addCin = 1'b1;
      end
      default: addCin = 1'b0;
    endcase
  end

  assign sum = {1'b0, addX} + {1'b0, addY} + {32'd0, addCin};

  always_comb begin
    case (aluOp)
      opAnd:   result = srcA & shOut;
      opEor:   result = srcA ^ shOut;
      opOrr:   result = srcA | shOut;
      opMov:   result = shOut;
      opMvn:   result = ~shOut;
      default: result = sum[31:0];
    endcase
  end

  assign flags.n = result[31];
  assign flags.z = (result == 32'd0);
  // Logical ops take C from the shifter
  assign flags.c = isArith(aluOp) ? sum[32] : shCarry;
  // Overflow when both adder inputs agree in sign and the sum does not
  assign flags.v = isArith(aluOp) && (addX[31] == addY[31]) && (sum[31] != addX[31]);

endmodule

// File: hdl/controller.sv
// Instruction decoder, stage control registers, flags register and condition check
module controller import legPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instrD,
  input  flagsT       aluFlagsE,
  input  logic        stallD,
  input  logic        flushD,
  input  logic        flushE,
  output ctrlT        ctrlE,
  output logic        branchTakenE,
  output logic        memToRegW,
  output logic        regWriteM,
  output logic        regWriteW,
  output logic        memReadE,
  output immSelT      immSelD
);

  ctrlT  ctrlD, ctrlEReg, ctrlM, ctrlW;
  flagsT flagsQ;
  logic  validD;
  logic  condPassE;

  // Condition field against NZCV
  function automatic logic condPass(condT cond, flagsT f);
    case (cond)
      condEq:  return f.z;
      condNe:  return !f.z;
      condCs:  return f.c;
      condCc:  return !f.c;
      condMi:  return f.n;
      condPl:  return !f.n;
      condVs:  return f.v;
      condVc:  return !f.v;
      condHi:  return f.c && !f.z;
      condLs:  return !f.c || f.z;
      condGe:  return f.n == f.v;
      condLt:  return f.n != f.v;
      condGt:  return !f.z && (f.n == f.v);
      condLe:  return f.z || (f.n != f.v);
      condAl:  return 1'b1;
      // The 4'b1111 space is not supported, treated as never
      default: return 1'b0;
    endcase
  endfunction

  // ==============================
  // Decode
  // ==============================

  always_comb begin
    ctrlD = '0;
    ctrlD.cond      = condT'(instrD[31:28]);
    ctrlD.shiftType = shiftT'(instrD[6:5]);
    ctrlD.shiftAmt  = instrD[11:7];
    immSelD = immRot;
    case (instrD[27:26])
      // Data processing
      2'b00: begin
        ctrlD.aluOp        = aluOpT'(instrD[24:21]);
        ctrlD.regWrite     = 1'b1;
        ctrlD.aluSrcImm    = instrD[25];
        ctrlD.shiftEn      = !instrD[25];
        // Compares only update flags
        ctrlD.writesResult = !(ctrlD.aluOp inside {opCmp, opCmn});
        ctrlD.setFlags     = instrD[20] || !ctrlD.writesResult;
      end
      // Word load or store, U bit picks add or subtract
      2'b01: begin
        ctrlD.memRead      = instrD[20];
        ctrlD.memWrite     = !instrD[20];
        ctrlD.regWrite     = instrD[20];
        ctrlD.writesResult = instrD[20];
        ctrlD.aluSrcImm    = 1'b1;
        ctrlD.aluOp        = instrD[23] ? opAdd : opSub;
        immSelD            = immLdSt;
      end
      // Branch target is PC+8 plus the shifted offset
      2'b10: begin
        ctrlD.branch    = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.aluOp     = opAdd;
        immSelD         = immBranch;
      end
      default: ctrlD = ctrlD;
    endcase
  end

  // Decode slot holds a real instruction
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validD <= 1'b0;
    end else if (!stallD) begin
      validD <= !flushD;
    end
  end

  // ==============================
  // Execute and later stages
  // ==============================

  always_ff @(posedge clk) begin
    if (!rstN || flushE || !validD) begin
      ctrlEReg <= '0;
    end else begin
      ctrlEReg <= ctrlD;
    end
  end

  assign condPassE = condPass(ctrlEReg.cond, flagsQ);

  // Failed condition turns the instruction into a no-op
  always_comb begin
    ctrlE = ctrlEReg;
    ctrlE.carry = flagsQ.c;
    ctrlE.regWrite = ctrlEReg.regWrite && ctrlEReg.writesResult && condPassE;
    if (!condPassE) begin
      ctrlE.memWrite = 1'b0;
      ctrlE.memRead  = 1'b0;
      ctrlE.setFlags = 1'b0;
      ctrlE.branch   = 1'b0;
    end
  end

  // Flags written at the end of Execute, V only for arithmetic
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (ctrlE.setFlags) begin
      flagsQ.n <= aluFlagsE.n;
      flagsQ.z <= aluFlagsE.z;
      flagsQ.c <= aluFlagsE.c;
      flagsQ.v <= isArith(ctrlE.aluOp) ? aluFlagsE.v : flagsQ.v;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlM <= ctrlE;
      ctrlW <= ctrlM;
    end
  end

  assign branchTakenE = ctrlE.branch;
  assign memReadE     = ctrlE.memRead;
  assign regWriteM    = ctrlM.regWrite;
  assign regWriteW    = ctrlW.regWrite;
  assign memToRegW    = ctrlW.memRead;

endmodule

// File: hdl/datapath.sv
// Five-stage 32-bit datapath with PC, register file, immediates, forwarding and stage registers
module datapath import legPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  output logic [31:0] pcF,
  input  logic [31:0] instrF,
  output logic [31:0] instrD,
  input  logic [31:0] readDataM,
  output dataReqT     dataReq,
  input  ctrlT        ctrlE,
  input  immSelT      immSelD,
  input  logic        memToRegW,
  input  logic        regWriteW,
  input  logic        branchTakenE,
  input  fwdSelT      forwardA,
  input  fwdSelT      forwardB,
  input  logic        stallF,
  input  logic        stallD,
  input  logic        flushD,
  input  logic        flushE,
  output flagsT       aluFlagsE,
  output regAddrT     ra1D,
  output regAddrT     ra2D,
  output regAddrT     ra1E,
  output regAddrT     ra2E,
  output regAddrT     waE,
  output regAddrT     waM,
  output regAddrT     waW
);

  logic [31:0] pcPlus4F, pcNextF;
  logic [31:0] rd1D, rd2D, immD;
  logic [63:0] immDblD;
  logic        immRotD;
  regAddrT     waD;
  logic [31:0] rd1E, rd2E, immE, srcAE, writeDataE, srcBE, aluResultE;
  logic        immRotE, shCarryInE;
  logic [31:0] aluOutM, writeDataM;
  logic        memWriteM, memReadM;
  logic [31:0] aluOutW, readDataW, resultW;

  // Register value or a forwarded newer result
  function automatic logic [31:0] fwdMux(fwdSelT sel, logic [31:0] regVal,
                                         logic [31:0] wbVal, logic [31:0] memVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  // ==============================
  // Fetch
  // ==============================

  assign pcPlus4F = pcF + 32'd4;
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcNextF;
    end
  end

  always_ff @(posedge clk) begin
    if (flushD) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  // ==============================
  // Decode
  // ==============================

  // Branch reads r15 as its base, a store reads Rd as its data
  assign ra1D = (immSelD == immBranch) ? 4'd15 : instrD[19:16];
  assign ra2D = (immSelD == immLdSt) ? instrD[15:12] : instrD[3:0];
  assign waD  = instrD[15:12];

  // Decode instruction sits at pcF-4, so its PC+8 is pcF+4
  regFile regFile_i (
    .clk, .we(regWriteW), .ra1(ra1D), .ra2(ra2D), .wa(waW), .wd(resultW),
    .pcPlus8(pcPlus4F), .rd1(rd1D), .rd2(rd2D)
  );

  // 8-bit value rotated right by twice the rotate field
  assign immDblD = {2{24'b0, instrD[7:0]}} >> {instrD[11:8], 1'b0};
  assign immRotD = (immSelD == immRot) && (instrD[11:8] != 4'd0);

  always_comb begin
    case (immSelD)
      immLdSt:   immD = {20'b0, instrD[11:0]};
      immBranch: immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
      default:   immD = immDblD[31:0];
    endcase
  end

  // ==============================
  // Execute
  // ==============================

  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    immE    <= immD;
    immRotE <= immRotD;
  end

  // Bubbles carry no register numbers
  always_ff @(posedge clk) begin
    if (flushE) begin
      ra1E <= '0;
      ra2E <= '0;
      waE  <= '0;
    end else begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      waE  <= waD;
    end
  end

  assign srcAE      = fwdMux(forwardA, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(forwardB, rd2E, resultW, aluOutM);
  assign srcBE      = ctrlE.aluSrcImm ? immE : writeDataE;

  // A rotated immediate sets C from its top bit
  assign shCarryInE = (ctrlE.aluSrcImm && immRotE) ? immE[31] : ctrlE.carry;

  aluShifter aluShifter_i (
    .srcA(srcAE), .srcB(srcBE), .shiftType(ctrlE.shiftType),
    .shiftAmt(ctrlE.shiftAmt), .shiftEn(ctrlE.shiftEn), .aluOp(ctrlE.aluOp),
    .carryIn(shCarryInE), .result(aluResultE), .flags(aluFlagsE)
  );

  // ==============================
  // Memory
  // ==============================

  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    waM        <= waE;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWriteM <= 1'b0;
      memReadM  <= 1'b0;
    end else begin
      memWriteM <= ctrlE.memWrite;
      memReadM  <= ctrlE.memRead;
    end
  end

  assign dataReq.addr  = aluOutM;
  assign dataReq.wdata = writeDataM;
  assign dataReq.we    = memWriteM;
  assign dataReq.re    = memReadM;

  // ==============================
  // Writeback
  // ==============================

  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
    waW       <= waM;
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

// File: hdl/hazardUnit.sv
// Forwarding selects, load-use stall and branch flush logic
module hazardUnit import legPkg::*; (
  input  regAddrT ra1D,
  input  regAddrT ra2D,
  input  regAddrT ra1E,
  input  regAddrT ra2E,
  input  regAddrT waE,
  input  regAddrT waM,
  input  regAddrT waW,
  input  logic    regWriteM,
  input  logic    regWriteW,
  input  logic    memReadE,
  input  logic    branchTakenE,
  output fwdSelT  forwardA,
  output fwdSelT  forwardB,
  output logic    stallF,
  output logic    stallD,
  output logic    flushD,
  output logic    flushE
);

  logic ldStall;

  // Memory stage is the younger producer, so it wins
  function automatic fwdSelT pickFwd(regAddrT ra, regAddrT wm, regAddrT ww,
                                     logic weM, logic weW);
    if (ra == 4'd15) begin
      return fwdNone;
    end else if (weM && (wm == ra)) begin
      return fwdMem;
    end else if (weW && (ww == ra)) begin
      return fwdWb;
    end
    return fwdNone;
  endfunction

  assign forwardA = pickFwd(ra1E, waM, waW, regWriteM, regWriteW);
  assign forwardB = pickFwd(ra2E, waM, waW, regWriteM, regWriteW);

  // Load in Execute feeding the instruction in Decode
  assign ldStall = memReadE && ((waE == ra1D) || (waE == ra2D));

  assign stallF = ldStall;
  assign stallD = ldStall;
  // Taken branch kills the two younger instructions
  assign flushD = branchTakenE;
  assign flushE = ldStall || branchTakenE;

endmodule

// File: hdl/legCore.sv
// Pipelined core top level: controller, datapath and hazard unit wired to memory ports
module legCore import legPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  output logic [31:0] pcF,
  input  logic [31:0] instrF,
  output dataReqT     dataReq,
  input  logic [31:0] readDataM
);

  // Controller to datapath
  logic [31:0] instrD;
  ctrlT        ctrlE;
  immSelT      immSelD;
  logic        branchTakenE, memToRegW, regWriteM, regWriteW, memReadE;
  flagsT       aluFlagsE;

  // Hazard unit signals
  regAddrT     ra1D, ra2D, ra1E, ra2E, waE, waM, waW;
  fwdSelT      forwardA, forwardB;
  logic        stallF, stallD, flushD, flushE;

  controller controller_i (
    .clk, .rstN, .instrD, .aluFlagsE,
    .stallD, .flushD, .flushE,
    .ctrlE, .branchTakenE, .memToRegW, .regWriteM, .regWriteW,
    .memReadE, .immSelD
  );

  datapath datapath_i (
    .clk, .rstN, .pcF, .instrF, .instrD, .readDataM, .dataReq,
    .ctrlE, .immSelD, .memToRegW, .regWriteW, .branchTakenE,
    .forwardA, .forwardB, .stallF, .stallD, .flushD, .flushE,
    .aluFlagsE,
    .ra1D, .ra2D, .ra1E, .ra2E, .waE, .waM, .waW
  );

  hazardUnit hazardUnit_i (
    .ra1D, .ra2D, .ra1E, .ra2E, .waE, .waM, .waW,
    .regWriteM, .regWriteW, .memReadE, .branchTakenE,
    .forwardA, .forwardB, .stallF, .stallD, .flushD, .flushE
  );

endmodule

// File: hdl/legPkg.sv
// Shared types for the core: opcodes, conditions, shifts, flags, control and data port
package legPkg;

  // ==============================
  // Instruction field encodings
  // ==============================

  // Data-processing opcodes, values match instr[24:21]
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opMvn = 4'b1111
  } aluOpT;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl
  } condT;

  // Shift type of the register operand, instr[6:5]
  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftT;

  // Which immediate Decode builds
  typedef enum logic [1:0] {
    immRot    = 2'b00,
    immLdSt   = 2'b01,
    immBranch = 2'b10
  } immSelT;

  // Forwarding source for an Execute operand
  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdWb   = 2'b01,
    fwdMem  = 2'b10
  } fwdSelT;

  typedef logic [3:0] regAddrT;

  // ==============================
  // Structs
  // ==============================

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Per-instruction control, decoded once and carried down the pipe
  typedef struct packed {
    logic    regWrite;
    logic    memWrite;
    logic    memRead;
    logic    setFlags;
    logic    branch;
    logic    aluSrcImm;
    logic    shiftEn;
    logic    writesResult;
    logic    carry;
    shiftT   shiftType;
    logic [4:0] shiftAmt;
    aluOpT   aluOp;
    condT    cond;
  } ctrlT;

  // Memory-stage data port request
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic        re;
  } dataReqT;

  // True for the opcodes that go through the adder
  function automatic logic isArith(aluOpT op);
    return (op == opAdd) || (op == opSub) || (op == opRsb) ||
           (op == opCmp) || (op == opCmn);
  endfunction

endpackage

// File: hdl/regFile.sv
// Fifteen-entry register file with write-through reads and r15 as PC+8
module regFile import legPkg::*; (
  input  logic        clk,
  input  logic        we,
  input  regAddrT     ra1,
  input  regAddrT     ra2,
  input  regAddrT     wa,
  input  logic [31:0] wd,
  input  logic [31:0] pcPlus8,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [15];

  // r15 is never written
  always_ff @(posedge clk) begin
    if (we && (wa != 4'd15)) begin
      regs[wa] <= wd;
    end
  end

  // Same-cycle write shows up on the read port
  always_comb begin
    if (ra1 == 4'd15) begin
      rd1 = pcPlus8;
    end else if (we && (wa == ra1)) begin
      rd1 = wd;
    end else begin
      rd1 = regs[ra1];
    end
    if (ra2 == 4'd15) begin
      rd2 = pcPlus8;
    end else if (we && (wa == ra2)) begin
      rd2 = wd;
    end else begin
      rd2 = regs[ra2];
    end
  end

endmodule

// File: sim.f
hdl/legPkg.sv
hdl/aluShifter.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/controller.sv
hdl/datapath.sv
hdl/legCore.sv
sim/tbClock.sv
sim/legCoreTb.sv

// File: sim/legCoreTb.sv
// Testbench for the pipelined core: program generator, ISA reference model, memories, store checks
module legCoreTb import legPkg::*; ();

  logic        clk, rstN;
  logic [31:0] pcF, instrF, readDataM;
  dataReqT     dataReq;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] refMem [256];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] rngState = 32'h2f7c;
  int          storeIdx, progNum;
  int          expLoads, loadCount;
  aluOpT       opList [10] = '{opAnd, opEor, opSub, opRsb, opAdd,
                               opCmp, opCmn, opOrr, opMov, opMvn};

  tbClock #(.Period(4)) tbClock_i (.clk);

  legCore legCore_i (
    .clk, .rstN, .pcF, .instrF, .dataReq, .readDataM
  );

  // ==============================
  // Memories
  // ==============================

  // Both ports answer in the same cycle
  assign instrF    = imem[pcF[9:2]];
  assign readDataM = dmem[dataReq.addr[9:2]];

  always @(posedge clk) begin
    if (rstN && dataReq.we) begin
      dmem[dataReq.addr[9:2]] <= dataReq.wdata;
    end
  end

  function automatic logic [31:0] fillWord(int i);
    return (32'(i) * 32'h9e3779b1) ^ 32'h13572468;
  endfunction

  // ==============================
  // Helpers
  // ==============================

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  function automatic int pick(int n);
    return int'(xorshift32() % 32'(n));
  endfunction

  task automatic checkEq(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] encDpImm(logic [3:0] cond, aluOpT op, logic s,
      logic [3:0] rn, logic [3:0] rd, logic [3:0] rot, logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic logic [31:0] encDpReg(logic [3:0] cond, aluOpT op, logic s,
      logic [3:0] rn, logic [3:0] rd, logic [4:0] amt, shiftT st, logic [3:0] rm);
    return {cond, 2'b00, 1'b0, op, s, rn, rd, amt, st, 1'b0, rm};
  endfunction

  // Word access, pre-indexed offset, no writeback
  function automatic logic [31:0] encMem(logic [3:0] cond, logic u, logic l,
      logic [3:0] rn, logic [3:0] rd, logic [11:0] off);
    return {cond, 3'b010, 1'b1, u, 2'b00, l, rn, rd, off};
  endfunction

  function automatic logic [31:0] encB(logic [3:0] cond, logic [23:0] off);
    return {cond, 4'b1010, off};
  endfunction

  // ==============================
  // Program generator
  // ==============================

  task automatic buildProgram();
    int n, kind, k;
    logic [3:0] cond, rd, rn, rm;
    logic [3:0] hist [3];
    aluOpT op;
    logic s, writes;
    n = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'd0;
    end
    // r0..r7 random, r8 is the data base 0x280, r9 the result base 0x100
    for (int r = 0; r < 8; r++) begin
      imem[n++] = encDpImm(4'hE, opMov, 1'b0, 4'd0, 4'(r), 4'(pick(16)), 8'(pick(256)));
    end
    imem[n++] = encDpImm(4'hE, opMov, 1'b0, 4'd0, 4'd8, 4'd14, 8'h28);
    imem[n++] = encDpImm(4'hE, opMov, 1'b0, 4'd0, 4'd9, 4'd12, 8'h01);
    // Defined flags before any conditional instruction
    imem[n++] = encDpReg(4'hE, opCmp, 1'b1, 4'd0, 4'd0, 5'd0, shLsl, 4'd1);
    hist = '{4'd0, 4'd1, 4'd2};
    for (int j = 0; j < 40; j++) begin
      cond = (pick(2) == 0) ? 4'hE : 4'(pick(15));
      rd = 4'(pick(8));
      // Recent destinations as sources give forwarding at distance 1 to 3
      rn = (pick(3) != 0) ? hist[pick(3)] : 4'(pick(8));
      rm = (pick(3) != 0) ? hist[pick(3)] : 4'(pick(8));
      op = opList[pick(10)];
      s = (op inside {opCmp, opCmn}) ? 1'b1 : 1'(pick(2));
      writes = !(op inside {opCmp, opCmn});
      kind = pick(10);
      k = 1 + pick(3);
      if (kind >= 9 && j + k <= 39) begin
        imem[n++] = encB(cond, 24'(k - 1));
        writes = 1'b0;
      end else if (kind >= 7) begin
        writes = 1'(pick(2));
        imem[n++] = encMem(cond, 1'(pick(2)), writes, 4'd8, writes ? rd : rm,
                           12'(pick(32) * 4));
      end else if (kind >= 4) begin
        imem[n++] = encDpReg(cond, op, s, rn, rd, 5'(pick(32)), shiftT'(pick(4)), rm);
      end else begin
        imem[n++] = encDpImm(cond, op, s, rn, rd, 4'(pick(16)), 8'(pick(256)));
      end
      if (writes) begin
        hist[0] = hist[1];
        hist[1] = hist[2];
        hist[2] = rd;
      end
    end
    for (int r = 0; r < 8; r++) begin
      imem[n++] = encMem(4'hE, 1'b1, 1'b0, 4'd9, 4'(r), 12'(r * 4));
    end
    // Branch to itself ends the program
    imem[n++] = encB(4'hE, 24'hfffffe);
  endtask

  // ==============================
  // Reference model
  // ==============================

  function automatic logic condHolds(logic [3:0] cond, logic n, logic z, logic c, logic v);
    case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return !z && (n == v);
      4'hD: return z || (n != v);
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] ror32(logic [31:0] x, int k);
    return (k == 0) ? x : ((x >> k) | (x << (32 - k)));
  endfunction

  // Interprets imem instruction by instruction, collecting stores and executed loads
  function automatic void runModel();
    logic [31:0] r [16];
    logic [31:0] pc, ins, a, sh, x, y, res, addr, target;
    logic [32:0] wide;
    logic n, z, c, v, shc, pass, arith;
    int amt;
    pc = 0;
    {n, z, c, v} = 4'b0000;
    for (int i = 0; i < 16; i++) begin
      r[i] = 32'd0;
    end
    for (int i = 0; i < 256; i++) begin
      refMem[i] = fillWord(i);
    end
    expAddr.delete();
    expData.delete();
    expLoads = 0;
    for (int step = 0; step < 1000; step++) begin
      ins = imem[pc[9:2]];
      pass = condHolds(ins[31:28], n, z, c, v);
      if (ins[27:25] == 3'b101) begin
        target = pc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
        if (pass && target == pc) begin
          break;
        end
        pc = pass ? target : pc + 32'd4;
        continue;
      end
      if (ins[27:26] == 2'b01) begin
        addr = ins[23] ? r[ins[19:16]] + ins[11:0] : r[ins[19:16]] - ins[11:0];
        if (pass && ins[20]) begin
          r[ins[15:12]] = refMem[addr[9:2]];
          expLoads++;
        end else if (pass) begin
          refMem[addr[9:2]] = r[ins[15:12]];
          expAddr.push_back(addr);
          expData.push_back(r[ins[15:12]]);
        end
        pc += 32'd4;
        continue;
      end
      // Shifter operand
      amt = int'(ins[11:7]);
      if (ins[25]) begin
        sh  = ror32({24'd0, ins[7:0]}, 2 * int'(ins[11:8]));
        shc = (ins[11:8] == 4'd0) ? c : sh[31];
      end else begin
        x = r[ins[3:0]];
        case (ins[6:5])
          2'b00: begin
            sh  = x << amt;
            shc = (amt == 0) ? c : x[32 - amt];
          end
          2'b01: begin
            sh  = (amt == 0) ? 32'd0 : x >> amt;
            shc = (amt == 0) ? x[31] : x[amt - 1];
          end
          2'b10: begin
            sh  = (amt == 0) ? {32{x[31]}} : 32'($signed(x) >>> amt);
            shc = (amt == 0) ? x[31] : x[amt - 1];
          end
          default: begin
            sh  = (amt == 0) ? {c, x[31:1]} : ror32(x, amt);
            shc = (amt == 0) ? x[0] : x[amt - 1];
          end
        endcase
      end
      a = r[ins[19:16]];
      arith = 1'b1;
      // Subtraction as a plus not b plus one
      case (ins[24:21])
        4'b0010, 4'b1010: {x, y, wide[0]} = {a, ~sh, 1'b1};
        4'b0011:          {x, y, wide[0]} = {sh, ~a, 1'b1};
        4'b0100, 4'b1011: {x, y, wide[0]} = {a, sh, 1'b0};
        default: begin
          {x, y, wide[0]} = {a, sh, 1'b0};
          arith = 1'b0;
        end
      endcase
      wide = {1'b0, x} + {1'b0, y} + {32'd0, wide[0]};
      case (ins[24:21])
        4'b0000: res = a & sh;
        4'b0001: res = a ^ sh;
        4'b1100: res = a | sh;
        4'b1101: res = sh;
        4'b1111: res = ~sh;
        default: res = wide[31:0];
      endcase
      if (pass) begin
        if (ins[20]) begin
          n = res[31];
          z = (res == 32'd0);
          c = arith ? wide[32] : shc;
          v = arith ? ((x[31] == y[31]) && (res[31] != x[31])) : v;
        end
        if (!(ins[24:21] inside {4'b1010, 4'b1011})) begin
          r[ins[15:12]] = res;
        end
      end
      pc += 32'd4;
    end
  endfunction

  // ==============================
  // Store compare
  // ==============================

  always @(negedge clk) begin
    // One read cycle per executed load
    if (rstN && dataReq.re === 1'b1) begin
      loadCount++;
    end
    if (rstN && dataReq.we === 1'b1) begin
      if (storeIdx >= expAddr.size()) begin
        $display("program %0d wrote an unexpected store to address %h", progNum,
                 dataReq.addr);
        $display("ERRORS FOUND");
        $fatal(1);
      end else begin
        checkEq($sformatf("prog%0d store%0d addr", progNum, storeIdx),
                expAddr[storeIdx], dataReq.addr);
        checkEq($sformatf("prog%0d store%0d data", progNum, storeIdx),
                expData[storeIdx], dataReq.wdata);
        storeIdx++;
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    int cycles;
    rstN = 1'b0;
    storeIdx = 0;
    loadCount = 0;
    progNum = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'd0;
      dmem[i] = 32'd0;
    end
    for (int p = 0; p < 15; p++) begin
      @(negedge clk);
      rstN = 1'b0;
      progNum = p;
      buildProgram();
      for (int i = 0; i < 256; i++) begin
        dmem[i] = fillWord(i);
      end
      runModel();
      storeIdx = 0;
      loadCount = 0;
      repeat (10) begin
        @(negedge clk);
        checkEq("reset pcF", 32'd0, pcF);
        checkEq("reset we", 32'd0, 32'(dataReq.we));
      end
      rstN = 1'b1;
      checkEq("release pcF", 32'd0, pcF);
      checkEq("release we", 32'd0, 32'(dataReq.we));
      cycles = 0;
      while (storeIdx < expAddr.size()) begin
        @(posedge clk);
        cycles++;
        if (cycles > 3000) begin
          $display("program %0d never finished, only %0d of %0d stores seen", p,
                   storeIdx, expAddr.size());
          $display("ERRORS FOUND");
          $fatal(1);
        end
      end
      // Idle a little so stray stores from the end loop get caught
      repeat (8) @(posedge clk);
      checkEq($sformatf("prog%0d load count", p), 32'(expLoads), 32'(loadCount));
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: sim/tbClock.sv
// Free-running testbench clock source
module tbClock #(
  parameter int Period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half period high, half period low
  always #(Period / 2) clk = ~clk;

endmodule
